/* include/balance_mac_defs.svh */
/*
 * balance_mac shared sizes
 * word width, coefficient lanes, coefficient width, result FIFO depth
 * and the width of the completion counter
 */

`ifndef BALANCE_MAC_DEFS_SVH
`define BALANCE_MAC_DEFS_SVH

//////////////////////////////////////////////////
// input side

// bits per input word
`define BM_WORD_WIDTH 32

//////////////////////////////////////////////////
// multiply-add side

// number of coefficient lanes, must be a power of two
`define BM_NUM_LANES 16

// coefficient width, also the width of data_out
`define BM_COEF_WIDTH 8

// entries in the result FIFO
`define BM_FIFO_DEPTH 512

// completed words since reset
`define BM_COUNT_WIDTH 64

`endif

/* verilog/balance_mac_pkg.sv */
/*
 * balance_mac types
 * signed bit-balance result, unsigned coefficient and sum value,
 * and the completion count
 */

`include "balance_mac_defs.svh"

package balance_mac_pkg;

   // enough bits for -WORD_WIDTH .. +WORD_WIDTH
   localparam int BALANCE_WIDTH = $clog2(2 * `BM_WORD_WIDTH + 1);

   // ones minus zeros of one word
   typedef logic signed [BALANCE_WIDTH-1:0] balance_t;

   // lane coefficient, product and sum, all modulo 2^coef width
   typedef logic [`BM_COEF_WIDTH-1:0] coef_t;

   // number of finished words
   typedef logic [`BM_COUNT_WIDTH-1:0] count_t;

endpackage

/* verilog/bit_balance.sv */
/*
 * bit_balance
 * walks a captured word one bit per cycle, LSB first, and counts
 * ones minus zeros. done rises WIDTH+1 cycles after go is taken and
 * holds, with result, until the next go
 */

`timescale 1ns/1ps
`include "balance_mac_defs.svh"

module bit_balance #(
   parameter int WIDTH = `BM_WORD_WIDTH
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      go,
   input  logic [WIDTH-1:0]          data,
   output balance_mac_pkg::balance_t result,
   output logic                      done
);

   typedef enum logic [1:0] {IDLE, COMPUTE, FINISHED} state_t;

   state_t                    state_r;
   logic [WIDTH-1:0]          data_r;
   logic [$clog2(WIDTH)-1:0]  bit_cnt_r;
   balance_mac_pkg::balance_t diff_r;
   balance_mac_pkg::balance_t diff_next;
   balance_mac_pkg::balance_t result_r;
   logic                      done_r;
   logic                      last_bit;
   logic                      start;

   // go is only honoured outside of COMPUTE
   assign start     = go && (state_r != COMPUTE);
   assign last_bit  = (state_r == COMPUTE) && (bit_cnt_r == WIDTH - 1);
   assign diff_next = data_r[0] ? diff_r + 1'b1 : diff_r - 1'b1;

   //////////////////////////////////////////////////
   // control FSM

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_r   <= IDLE;
         done_r    <= 1'b0;
         bit_cnt_r <= '0;
         diff_r    <= '0;
      end else begin
         case (state_r)
            IDLE, FINISHED: begin
               // a new go in FINISHED starts straight away
               if (go) begin
                  done_r    <= 1'b0;
                  bit_cnt_r <= '0;
                  diff_r    <= '0;
                  state_r   <= COMPUTE;
               end
            end
            COMPUTE: begin
               diff_r    <= diff_next;
               bit_cnt_r <= bit_cnt_r + 1'b1;
               if (last_bit) begin
                  done_r  <= 1'b1;
                  state_r <= FINISHED;
               end
            end
            default: state_r <= IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // word shifter and result hold

   always_ff @(posedge clk) begin
      if (start) begin
         data_r <= data;
      end else if (state_r == COMPUTE) begin
         data_r <= data_r >> 1;
      end
      // result only moves on the final bit
      if (last_bit) begin
         result_r <= diff_next;
      end
   end

   assign result = result_r;
   assign done   = done_r;

endmodule

/* verilog/sync_fifo.sv */
/*
 * sync_fifo
 * single clock show-ahead FIFO. rd_data always holds the head, a pop
 * moves to the next entry on the following cycle. writes into a
 * full FIFO and reads from an empty one are dropped
 */

`timescale 1ns/1ps
`include "balance_mac_defs.svh"

module sync_fifo #(
   parameter int WIDTH = $bits(balance_mac_pkg::balance_t),
   parameter int DEPTH = `BM_FIFO_DEPTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             wr_en,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             rd_en,
   output logic [WIDTH-1:0] rd_data,
   output logic             full,
   output logic             almost_full,
   output logic             empty
);

   localparam int ADDR_WIDTH = $clog2(DEPTH);
   localparam int OCC_WIDTH  = $clog2(DEPTH) + 1;

   logic [WIDTH-1:0]      ram [DEPTH];
   logic [ADDR_WIDTH-1:0] wr_addr_r;
   logic [ADDR_WIDTH-1:0] rd_addr_r;
   logic [ADDR_WIDTH-1:0] rd_addr;
   logic [OCC_WIDTH-1:0]  occ_r;
   logic [WIDTH-1:0]      rd_data_r;
   logic                  wr_ok;
   logic                  rd_ok;

   assign wr_ok = wr_en && !full;
   assign rd_ok = rd_en && !empty;

   // look one entry ahead on a pop so the next head is ready in time
   assign rd_addr = rd_ok ? rd_addr_r + 1'b1 : rd_addr_r;

   //////////////////////////////////////////////////
   // storage

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         ram[wr_addr_r] <= wr_data;
      end
      // forward a write that lands on the head slot
      if (wr_ok && (wr_addr_r == rd_addr)) begin
         rd_data_r <= wr_data;
      end else begin
         rd_data_r <= ram[rd_addr];
      end
   end

   //////////////////////////////////////////////////
   // pointers and occupancy

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_addr_r <= '0;
         rd_addr_r <= '0;
         occ_r     <= '0;
      end else begin
         if (wr_ok) begin
            wr_addr_r <= wr_addr_r + 1'b1;
         end
         rd_addr_r <= rd_addr;
         case ({wr_ok, rd_ok})
            2'b10:   occ_r <= occ_r + 1'b1;
            2'b01:   occ_r <= occ_r - 1'b1;
            default: occ_r <= occ_r;
         endcase
      end
   end

   assign rd_data     = rd_data_r;
   assign full        = (occ_r == OCC_WIDTH'(DEPTH));
   assign almost_full = (occ_r >= OCC_WIDTH'(DEPTH - 1));
   assign empty       = (occ_r == '0);

endmodule

/* verilog/mac_tree.sv */
/*
 * mac_tree
 * multiplies one signed operand by NUM_LANES coefficients and sums the
 * products in a registered binary tree, all modulo 2^coef width.
 * latency is 3 + log2(NUM_LANES) cycles, 7 at 16 lanes
 */

`timescale 1ns/1ps
`include "balance_mac_defs.svh"

module mac_tree #(
   parameter int NUM_LANES = `BM_NUM_LANES
) (
   input  logic                      clk,
   input  logic                      rst,
   input  balance_mac_pkg::balance_t operand,
   input  logic                      operand_valid,
   input  balance_mac_pkg::coef_t    coef [NUM_LANES],
   output balance_mac_pkg::coef_t    sum,
   output logic                      sum_valid
);

   localparam int LEVELS  = $clog2(NUM_LANES);
   // operand, product and retiming stages ahead of the adders
   localparam int LATENCY = 3 + LEVELS;
   // heap-ordered tree, root at 0, leaves at NUM_LANES-1 and up
   localparam int NODES   = 2 * NUM_LANES - 1;

   balance_mac_pkg::balance_t operand_r;
   balance_mac_pkg::coef_t    operand_ext;
   balance_mac_pkg::coef_t    prod_r [NUM_LANES];
   balance_mac_pkg::coef_t    node_r [NODES];
   logic [LATENCY-1:0]        valid_r;

   // sign extend, the low bits of the product then come out right
   assign operand_ext = balance_mac_pkg::coef_t'(operand_r);

   //////////////////////////////////////////////////
   // multipliers

   always_ff @(posedge clk) begin
      operand_r <= operand;
      for (int i = 0; i < NUM_LANES; i++) begin
         prod_r[i] <= coef[i] * operand_ext;
      end
   end

   //////////////////////////////////////////////////
   // adder tree

   // leaves retime the products, each inner node adds its two children.
   // the root is the output register
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_LANES; i++) begin
         node_r[NUM_LANES-1+i] <= prod_r[i];
      end
      for (int n = 0; n < NUM_LANES - 1; n++) begin
         node_r[n] <= node_r[2*n+1] + node_r[2*n+2];
      end
   end

   assign sum = node_r[0];

   //////////////////////////////////////////////////
   // valid delay line

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end else begin
         valid_r <= {valid_r[LATENCY-2:0], operand_valid};
      end
   end

   assign sum_valid = valid_r[LATENCY-1];

endmodule

/* verilog/balance_mac_top.sv */
/*
 * balance_mac_top
 * bit balance of each accepted word goes through a result FIFO into
 * a lane-weighted multiply-add tree. ready paces the source, count
 * tracks finished words since reset
 */

`timescale 1ns/1ps
`include "balance_mac_defs.svh"

module balance_mac_top (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [`BM_WORD_WIDTH-1:0]    data_in,
   input  logic                         data_in_valid,
   input  balance_mac_pkg::coef_t       coef [`BM_NUM_LANES],
   output logic                         ready,
   output balance_mac_pkg::coef_t       data_out,
   output logic                         data_out_valid,
   output balance_mac_pkg::count_t      count
);

   balance_mac_pkg::balance_t balance_result;
   balance_mac_pkg::balance_t fifo_head;
   balance_mac_pkg::count_t   count_r;
   logic                      balance_done;
   logic                      done_r;
   logic                      done_rise;
   logic                      first_word_r;
   logic                      fifo_wr_r;
   logic                      fifo_rd;
   logic                      fifo_almost_full;
   logic                      fifo_empty;

   //////////////////////////////////////////////////
   // bit balance counter

   bit_balance #(
      .WIDTH (`BM_WORD_WIDTH)
   ) u_bit_balance (
      .clk    (clk),
      .rst    (rst),
      .go     (data_in_valid),
      .data   (data_in),
      .result (balance_result),
      .done   (balance_done)
   );

   //////////////////////////////////////////////////
   // completion tracking

   assign done_rise = balance_done && !done_r;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_r       <= 1'b0;
         first_word_r <= 1'b1;
         fifo_wr_r    <= 1'b0;
         count_r      <= '0;
      end else begin
         done_r    <= balance_done;
         // one write per finished word
         fifo_wr_r <= done_rise;
         if (done_rise) begin
            count_r <= count_r + 1'b1;
         end
         if (data_in_valid && ready) begin
            first_word_r <= 1'b0;
         end
      end
   end

   // done_r holds off the next word until the pending write is in
   assign ready = first_word_r || (balance_done && done_r && !fifo_almost_full);
   assign count = count_r;

   //////////////////////////////////////////////////
   // result FIFO

   sync_fifo #(
      .WIDTH ($bits(balance_mac_pkg::balance_t)),
      .DEPTH (`BM_FIFO_DEPTH)
   ) u_sync_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr_en       (fifo_wr_r),
      .wr_data     (balance_result),
      .rd_en       (fifo_rd),
      .rd_data     (fifo_head),
      .full        (),
      .almost_full (fifo_almost_full),
      .empty       (fifo_empty)
   );

   // no back-pressure downstream, drain whenever something is there
   assign fifo_rd = !fifo_empty;

   //////////////////////////////////////////////////
   // multiply-add tree

   mac_tree #(
      .NUM_LANES (`BM_NUM_LANES)
   ) u_mac_tree (
      .clk           (clk),
      .rst           (rst),
      .operand       (fifo_head),
      .operand_valid (fifo_rd),
      .coef          (coef),
      .sum           (data_out),
      .sum_valid     (data_out_valid)
   );

endmodule

/* testbench/balance_mac_tb.sv */
/*
 * balance_mac testbench
 * seeded random words and coefficients go into balance_mac_top. a model
 * predicts every data_out, and a scoreboard checks the results in order
 */

`timescale 1ns/1ps
`include "balance_mac_defs.svh"

module balance_mac_tb;

   logic                       clk;
   logic                       rst;
   logic [`BM_WORD_WIDTH-1:0]  data_in;
   logic                       data_in_valid;
   balance_mac_pkg::coef_t     coef [`BM_NUM_LANES];
   logic                       ready;
   balance_mac_pkg::coef_t     data_out;
   logic                       data_out_valid;
   balance_mac_pkg::count_t    count;

   balance_mac_pkg::coef_t     exp_q [$];
   int                         errors;
   int                         checks;
   int                         outputs_seen;
   longint unsigned            total_words;
   bit                         timed_out;

   balance_mac_top dut (
      .clk            (clk),
      .rst            (rst),
      .data_in        (data_in),
      .data_in_valid  (data_in_valid),
      .coef           (coef),
      .ready          (ready),
      .data_out       (data_out),
      .data_out_valid (data_out_valid),
      .count          (count)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // reference model

   // balance is 2*popcount - width followed by a weighted sum modulo 2^coef width
   function automatic balance_mac_pkg::coef_t expected_sum(logic [`BM_WORD_WIDTH-1:0] word);
      int ones;
      int bal;
      int acc;
      ones = 0;
      for (int i = 0; i < `BM_WORD_WIDTH; i++) begin
         ones += word[i];
      end
      bal = 2 * ones - `BM_WORD_WIDTH;
      acc = 0;
      for (int i = 0; i < `BM_NUM_LANES; i++) begin
         acc += int'(coef[i]) * bal;
      end
      return balance_mac_pkg::coef_t'(acc);
   endfunction

   task automatic report_mismatch(string name, longint unsigned exp, longint unsigned got);
      $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, got);
      errors++;
   endtask

   //////////////////////////////////////////////////
   // scoreboard

   // outputs sampled on the rising edge while inputs move on the falling edge
   always @(posedge clk) begin
      if (!rst && data_out_valid) begin
         outputs_seen++;
         if (exp_q.size() == 0) begin
            $display("data_out_valid at %0t with no word pending", $time);
            errors++;
         end else begin
            checks++;
            if (data_out !== exp_q[0]) begin
               report_mismatch("data_out", exp_q[0], data_out);
            end
            void'(exp_q.pop_front());
         end
      end
   end

   //////////////////////////////////////////////////
   // stimulus helpers

   task automatic apply_reset();
      @(negedge clk);
      rst = 1'b1;
      data_in_valid = 1'b0;
      exp_q.delete();
      total_words = 0;
      repeat (3) @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic wait_ready(int limit);
      int n;
      n = 0;
      while (!ready && !timed_out) begin
         if (n == limit) begin
            $display("ready stayed low for %0d cycles, giving up", limit);
            timed_out = 1'b1;
            errors++;
         end else begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic wait_drained(int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && !timed_out) begin
         if (n == limit) begin
            $display("%0d results never came out of the DUT", exp_q.size());
            timed_out = 1'b1;
            errors++;
         end else begin
            @(negedge clk);
            n++;
         end
      end
   endtask

   task automatic send_word(logic [`BM_WORD_WIDTH-1:0] word);
      wait_ready(200);
      if (!timed_out) begin
         data_in       = word;
         data_in_valid = 1'b1;
         exp_q.push_back(expected_sum(word));
         total_words++;
         @(negedge clk);
         data_in_valid = 1'b0;
      end
   endtask

   task automatic randomize_coef();
      for (int i = 0; i < `BM_NUM_LANES; i++) begin
         coef[i] = balance_mac_pkg::coef_t'($urandom());
      end
   endtask

   task automatic end_test(string name);
      $display("test %s finished, errors so far %0d", name, errors);
   endtask

   //////////////////////////////////////////////////
   // test sequence

   initial begin
      int seen_before;
      void'($urandom(30523));
      rst           = 1'b1;
      data_in       = '0;
      data_in_valid = 1'b0;
      errors        = 0;
      checks        = 0;
      outputs_seen  = 0;
      total_words   = 0;
      timed_out     = 1'b0;
      for (int i = 0; i < `BM_NUM_LANES; i++) begin
         coef[i] = '0;
      end
      apply_reset();

      // 1 reset state and a single word
      if (ready !== 1'b1) report_mismatch("ready", 1, ready);
      if (data_out_valid !== 1'b0) report_mismatch("data_out_valid", 0, data_out_valid);
      if (count !== '0) report_mismatch("count", 0, count);
      randomize_coef();
      send_word($urandom());
      wait_drained(500);
      if (count !== total_words) report_mismatch("count", total_words, count);
      end_test("single_word");

      // 2 corner words with a lane sum of 17 to keep +32 and -32 apart
      for (int i = 0; i < `BM_NUM_LANES; i++) begin
         coef[i] = 8'd1;
      end
      coef[0] = 8'd2;
      if (expected_sum('0) !== 8'd224) report_mismatch("model all zeros", 224, expected_sum('0));
      if (expected_sum('1) !== 8'd32) report_mismatch("model all ones", 32, expected_sum('1));
      send_word('0);
      send_word('1);
      send_word(32'haaaa_aaaa);
      send_word(32'h5555_5555);
      wait_drained(500);
      if (count !== total_words) report_mismatch("count", total_words, count);
      end_test("corner_words");

      // 3 back-to-back random stream
      randomize_coef();
      seen_before = outputs_seen;
      for (int i = 0; i < 200; i++) begin
         send_word($urandom());
      end
      wait_drained(500);
      if (outputs_seen - seen_before != 200) begin
         report_mismatch("outputs", 200, outputs_seen - seen_before);
      end
      if (count !== total_words) report_mismatch("count", total_words, count);
      end_test("random_stream");

      // 4 new coefficients while idle between bursts
      for (int b = 0; b < 3; b++) begin
         randomize_coef();
         for (int i = 0; i < 20; i++) begin
            send_word($urandom());
         end
         wait_drained(500);
      end
      if (count !== total_words) report_mismatch("count", total_words, count);
      end_test("coef_bursts");

      // 5 reset in the middle of a stream
      for (int i = 0; i < 3; i++) begin
         send_word($urandom());
      end
      repeat (10) @(negedge clk);
      apply_reset();
      if (ready !== 1'b1) report_mismatch("ready", 1, ready);
      if (count !== '0) report_mismatch("count", 0, count);
      seen_before = outputs_seen;
      repeat (80) @(negedge clk);
      if (outputs_seen != seen_before) begin
         $display("data_out_valid appeared after reset with no new word");
         errors++;
      end
      send_word($urandom());
      wait_drained(500);
      if (count !== 64'd1) report_mismatch("count", 1, count);
      end_test("mid_stream_reset");

      $display("checks %0d, outputs %0d, errors %0d", checks, outputs_seen, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* list.f */
+incdir+include
verilog/balance_mac_pkg.sv
verilog/bit_balance.sv
verilog/sync_fifo.sv
verilog/mac_tree.sv
verilog/balance_mac_top.sv
testbench/balance_mac_tb.sv

/* Bender.yml */
package:
  name: balance_mac

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/balance_mac_pkg.sv
      - verilog/bit_balance.sv
      - verilog/sync_fifo.sv
      - verilog/mac_tree.sv
      - verilog/balance_mac_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - testbench/balance_mac_tb.sv
